/* eth_mii_rx.f */
design/eth_rx_pkg.sv
design/eth_rx_crc.sv
design/eth_rx_frame.sv
design/eth_rx_buffer.sv
design/eth_rx_top.sv
sim/tb_eth_rx.sv

/* Makefile */
TOP = tb_eth_rx

sim:
	verilator --binary --timing --top-module $(TOP) -f eth_mii_rx.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* sim/tb_eth_rx.sv */
`timescale 1ns/10ps

module tb_eth_rx;

   localparam logic [47:0] STATION_ADDR = 48'h02_00_5E_10_20_30;
   localparam integer      BUF_ADDR_W   = 8;
   localparam int          BUF_DEPTH    = 2 ** BUF_ADDR_W;
   localparam int          MAC_LEN      = 6;

   // reflected CRC-32
   localparam logic [31:0] POLY         = 32'hEDB88320;

   localparam logic [31:0] LFSR_TAPS    = 32'h80200003;

   // 40 frames at the worst case per frame
   localparam int          MAX_CYCLES   = 40 * 2400;

   logic                  RX_CLK = 1'b0;
   logic                  rx_rst;
   logic                  rx_dv;
   logic [3:0]            rx_data;
   logic                  frame_ack;
   logic [BUF_ADDR_W-1:0] rd_addr;
   logic                  frame_ready;
   logic [BUF_ADDR_W:0]   frame_len;
   logic [7:0]            rd_data;
   logic [31:0]           crc_value;
   logic                  crc_ok;

   logic [31:0] lfsr_state = 32'ha576;
   logic [7:0]  tx_q[$];
   logic [7:0]  exp_q[$];
   int          cycle_count = 0;
   int          frames_sent = 0;
   int          mismatch_count = 0;
   int          failure_count = 0;

   eth_rx_top #(
      .STATION_ADDR (STATION_ADDR),
      .BUF_ADDR_W   (BUF_ADDR_W)
   ) DUT (
      .RX_CLK      (RX_CLK),
      .rx_rst      (rx_rst),
      .rx_dv       (rx_dv),
      .rx_data     (rx_data),
      .frame_ack   (frame_ack),
      .rd_addr     (rd_addr),
      .frame_ready (frame_ready),
      .frame_len   (frame_len),
      .rd_data     (rd_data),
      .crc_value   (crc_value),
      .crc_ok      (crc_ok)
   );

   always #4 RX_CLK = ~RX_CLK;

   always @(posedge RX_CLK) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("TB FAILED");
         $finish;
      end
   end

   // galois lfsr stepped once per bit
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         bits = {bits[30:0], lfsr_state[0]};
         if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
         end else begin
            lfsr_state = lfsr_state >> 1;
         end
      end
      return bits;
   endfunction

   function automatic int rand_range(input int lo, input int hi);
      return lo + int'(lfsr_bits(16)) % (hi - lo + 1);
   endfunction

   // reference CRC with data lsb first
   function automatic logic [31:0] crc_step(input logic [31:0] crc_in, input logic [7:0] data);
      logic [31:0] crc;
      logic        fb;
      crc = crc_in;
      for (int b = 0; b < 8; b++) begin
         fb  = crc[0] ^ data[b];
         crc = crc >> 1;
         if (fb) begin
            crc = crc ^ POLY;
         end
      end
      return crc;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("mismatch at time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      mismatch_count++;
   endtask

   task automatic report_failure(input string msg);
      $display("error at time %0t: %s", $time, msg);
      failure_count++;
   endtask

   // destination, payload and FCS with an optional bad byte or address
   task automatic build_frame(input int payload_len, input bit corrupt, input bit wrong_dest);
      logic [47:0] dest;
      logic [31:0] crc;
      int          idx;
      dest = STATION_ADDR;
      if (wrong_dest) begin
         idx       = rand_range(0, 47);
         dest[idx] = ~dest[idx];
      end
      tx_q.delete();
      for (int i = MAC_LEN - 1; i >= 0; i--) begin
         tx_q.push_back(dest[i*8 +: 8]);
      end
      for (int i = 0; i < payload_len; i++) begin
         tx_q.push_back(8'(lfsr_bits(8)));
      end
      crc = '1;
      foreach (tx_q[i]) begin
         crc = crc_step(crc, tx_q[i]);
      end
      crc = ~crc;
      tx_q.push_back(crc[7:0]);
      tx_q.push_back(crc[15:8]);
      tx_q.push_back(crc[23:16]);
      tx_q.push_back(crc[31:24]);
      if (corrupt) begin
         idx       = rand_range(MAC_LEN, tx_q.size() - 1);
         tx_q[idx] = tx_q[idx] ^ (8'h01 << lfsr_bits(3));
      end
   endtask

   task automatic send_nibble(input logic [3:0] nib);
      rx_dv   = 1'b1;
      rx_data = nib;
      @(negedge RX_CLK);
   endtask

   task automatic send_frame(input bit check_latency);
      int gap;
      int pre;
      gap     = rand_range(1, 8);
      pre     = rand_range(2, 15);
      rx_dv   = 1'b0;
      rx_data = 4'h0;
      repeat (gap) @(negedge RX_CLK);
      repeat (pre) send_nibble(4'h5);
      // SFD low nibble first
      send_nibble(4'h5);
      send_nibble(4'hD);
      foreach (tx_q[i]) begin
         send_nibble(tx_q[i][3:0]);
         send_nibble(tx_q[i][7:4]);
      end
      rx_dv   = 1'b0;
      rx_data = 4'h0;
      frames_sent++;
      if (check_latency) begin
         @(negedge RX_CLK);
         if (frame_ready !== 1'b0) begin
            report_failure("frame_ready rose one clock after the end of the frame");
         end
         @(negedge RX_CLK);
         if (frame_ready !== 1'b1) begin
            report_failure("frame_ready did not rise two clocks after the end of the frame");
         end
      end
   endtask

   task automatic check_ready_low(input int cycles, input string what);
      repeat (cycles) begin
         @(negedge RX_CLK);
         if (frame_ready !== 1'b0) begin
            report_failure({"frame_ready is high ", what});
         end
      end
   endtask

   // host reads the buffer and then runs the four-phase handshake
   task automatic read_frame(input bit intact);
      int          exp_len;
      int          extra;
      logic [31:0] crc;
      logic        exp_ok;
      while (frame_ready !== 1'b1) @(negedge RX_CLK);
      exp_len = (exp_q.size() > BUF_DEPTH) ? BUF_DEPTH : exp_q.size();
      crc = '1;
      for (int i = 0; i < exp_len; i++) begin
         crc = crc_step(crc, exp_q[i]);
      end
      // only a whole frame with its FCS unharmed is good
      exp_ok = intact && (exp_q.size() <= BUF_DEPTH);
      if (frame_len !== 9'(exp_len)) begin
         report_mismatch("frame_len", exp_len, frame_len);
      end
      if (crc_value !== ~crc) begin
         report_mismatch("crc_value", ~crc, crc_value);
      end
      if (crc_ok !== exp_ok) begin
         report_mismatch("crc_ok", exp_ok, crc_ok);
      end
      for (int i = 0; i < exp_len; i++) begin
         rd_addr = 8'(i);
         @(negedge RX_CLK);
         if (rd_data !== exp_q[i]) begin
            report_mismatch($sformatf("rd_data[%0d]", i), exp_q[i], rd_data);
         end
      end
      // still held after the read
      if (frame_len !== 9'(exp_len)) begin
         report_mismatch("frame_len", exp_len, frame_len);
      end
      if (crc_value !== ~crc) begin
         report_mismatch("crc_value", ~crc, crc_value);
      end
      frame_ack = 1'b1;
      @(negedge RX_CLK);
      if (frame_ready !== 1'b0) begin
         report_failure("frame_ready still high one clock after frame_ack");
      end
      extra = rand_range(0, 5);
      repeat (extra) @(negedge RX_CLK);
      while (frame_ready !== 1'b0) @(negedge RX_CLK);
      frame_ack = 1'b0;
   endtask

   task automatic run_frame(input int payload_len, input bit corrupt);
      build_frame(payload_len, corrupt, 1'b0);
      exp_q = tx_q;
      send_frame(1'b1);
      read_frame(!corrupt);
   endtask

   initial begin
      rx_rst    = 1'b1;
      rx_dv     = 1'b0;
      rx_data   = 4'h0;
      frame_ack = 1'b0;
      rd_addr   = '0;
      check_ready_low(3, "during reset");
      rx_rst = 1'b0;
      check_ready_low(4, "after reset");

      repeat (6) run_frame(rand_range(46, 100), 1'b0);

      repeat (3) run_frame(rand_range(46, 100), 1'b1);

      // wrong destination followed by a good frame
      repeat (2) begin
         build_frame(rand_range(46, 100), 1'b0, 1'b1);
         send_frame(1'b0);
         check_ready_low(6, "for a frame with a foreign address");
         run_frame(rand_range(46, 100), 1'b0);
      end

      // longer than the 256 byte buffer
      run_frame(300, 1'b0);

      // second frame arrives while the first is still held
      build_frame(rand_range(46, 100), 1'b0, 1'b0);
      exp_q = tx_q;
      send_frame(1'b1);
      build_frame(100, 1'b0, 1'b0);
      fork
         send_frame(1'b0);
         begin
            wait (rx_dv === 1'b1);
            repeat (8) @(negedge RX_CLK);
            read_frame(1'b1);
         end
      join
      check_ready_low(6, "for a frame sent during back-pressure");
      run_frame(rand_range(46, 100), 1'b0);

      // reset while a frame is offered
      build_frame(rand_range(46, 100), 1'b0, 1'b0);
      exp_q = tx_q;
      send_frame(1'b1);
      rx_rst = 1'b1;
      check_ready_low(3, "while reset is asserted");
      rx_rst = 1'b0;
      check_ready_low(4, "after reset");
      run_frame(rand_range(46, 100), 1'b0);

      $display("tb_eth_rx: %0d frames sent, %0d mismatches, %0d other errors",
               frames_sent, mismatch_count, failure_count);
      if (mismatch_count + failure_count == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* design/eth_rx_top.sv */
`timescale 1ns/10ps

module eth_rx_top #(
   parameter eth_rx_pkg::mac_addr_t STATION_ADDR = 48'h02_00_00_00_00_01,
   parameter integer                BUF_ADDR_W   = 11
) (
   input  logic                  RX_CLK,
   input  logic                  rx_rst,
   input  logic                  rx_dv,
   input  eth_rx_pkg::nibble_t   rx_data,
   input  logic                  frame_ack,
   input  logic [BUF_ADDR_W-1:0] rd_addr,
   output logic                  frame_ready,
   output logic [BUF_ADDR_W:0]   frame_len,
   output eth_rx_pkg::byte_t     rd_data,
   output eth_rx_pkg::crc_t      crc_value,
   output logic                  crc_ok
);
   import eth_rx_pkg::*;

   logic                  rst_sync;
   logic                  wr_en;
   logic [BUF_ADDR_W-1:0] wr_addr;
   byte_t                 wr_data;
   logic                  crc_start;

   eth_rx_frame #(
      .STATION_ADDR (STATION_ADDR),
      .BUF_ADDR_W   (BUF_ADDR_W)
   ) u_frame (
      .RX_CLK      (RX_CLK),
      .rx_rst      (rx_rst),
      .rx_dv       (rx_dv),
      .rx_data     (rx_data),
      .frame_ack   (frame_ack),
      .rst_sync    (rst_sync),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .crc_start   (crc_start),
      .frame_ready (frame_ready),
      .frame_len   (frame_len)
   );

   // CRC sees exactly the stored bytes
   eth_rx_crc u_crc (
      .RX_CLK    (RX_CLK),
      .rst_sync  (rst_sync),
      .crc_start (crc_start),
      .crc_en    (wr_en),
      .crc_data  (wr_data),
      .crc_value (crc_value),
      .crc_ok    (crc_ok)
   );

   eth_rx_buffer #(
      .BUF_ADDR_W (BUF_ADDR_W)
   ) u_buffer (
      .RX_CLK  (RX_CLK),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

/* design/eth_rx_buffer.sv */
`timescale 1ns/10ps

module eth_rx_buffer #(
   parameter integer BUF_ADDR_W = 11
) (
   input  logic                  RX_CLK,
   input  logic                  wr_en,
   input  logic [BUF_ADDR_W-1:0] wr_addr,
   input  eth_rx_pkg::byte_t     wr_data,
   input  logic [BUF_ADDR_W-1:0] rd_addr,
   output eth_rx_pkg::byte_t     rd_data
);
   import eth_rx_pkg::*;

   localparam integer DEPTH = 2 ** BUF_ADDR_W;

   // one frame, destination address first
   byte_t mem [DEPTH];

   always_ff @(posedge RX_CLK) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered read, one clock after rd_addr
   always_ff @(posedge RX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* design/eth_rx_frame.sv */
`timescale 1ns/10ps

module eth_rx_frame #(
   parameter eth_rx_pkg::mac_addr_t STATION_ADDR = 48'h02_00_00_00_00_01,
   parameter integer                BUF_ADDR_W   = 11
) (
   input  logic                  RX_CLK,
   input  logic                  rx_rst,
   input  logic                  rx_dv,
   input  eth_rx_pkg::nibble_t   rx_data,
   input  logic                  frame_ack,
   output logic                  rst_sync,
   output logic                  wr_en,
   output logic [BUF_ADDR_W-1:0] wr_addr,
   output eth_rx_pkg::byte_t     wr_data,
   output logic                  crc_start,
   output logic                  frame_ready,
   output logic [BUF_ADDR_W:0]   frame_len
);
   import eth_rx_pkg::*;

   localparam logic [BUF_ADDR_W:0] LAST_DEST_CNT = (BUF_ADDR_W + 1)'(MAC_ADDR_LEN - 1);

   logic [1:0]          rst_pipe;
   frame_state_t        state;
   byte_t               nib_shift;
   byte_t               data_int;
   mac_addr_t           dest_shift;
   logic                phase;
   logic [BUF_ADDR_W:0] byte_cnt;
   logic                receiving;
   logic                byte_done;
   logic                buf_full;

   // async assert, release after two edges
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         rst_pipe <= 2'b11;
      end else begin
         rst_pipe <= {rst_pipe[0], 1'b0};
      end
   end

   assign rst_sync = rst_pipe[1];

   // new nibble goes into the high half
   assign data_int = {rx_data, nib_shift[7:4]};

   always_ff @(posedge RX_CLK) begin
      if (rx_dv) begin
         nib_shift <= data_int;
      end
   end

   assign receiving = (state == st_dest_addr) || (state == st_check_addr) ||
                      (state == st_payload);

   // second nibble of a byte
   assign byte_done = receiving && rx_dv && phase;

   assign buf_full = byte_cnt[BUF_ADDR_W];

   // first destination byte ends up on top
   always_ff @(posedge RX_CLK) begin
      if (byte_done && state == st_dest_addr) begin
         dest_shift <= {dest_shift[39:0], data_int};
      end
   end

   always_ff @(posedge RX_CLK or posedge rst_sync) begin
      if (rst_sync) begin
         state       <= st_idle;
         phase       <= 1'b0;
         byte_cnt    <= '0;
         wr_en       <= 1'b0;
         frame_ready <= 1'b0;
      end else begin
         // write on the cycle after the byte completes
         wr_en <= byte_done && !buf_full;

         if (receiving && rx_dv) begin
            phase <= ~phase;
         end

         // saturates since no write is issued once full
         if (wr_en) begin
            byte_cnt <= byte_cnt + 1'b1;
         end

         case (state)
            st_idle: begin
               phase    <= 1'b0;
               byte_cnt <= '0;
               if (rx_dv) begin
                  if (rx_data == ETH_SFD[3:0]) begin
                     state <= st_sfd_low;
                  end else begin
                     state <= st_drop;
                  end
               end
            end

            // preamble nibbles until the SFD high half
            st_sfd_low: begin
               if (!rx_dv) begin
                  state <= st_idle;
               end else if (data_int == ETH_SFD) begin
                  state <= st_dest_addr;
               end else if (rx_data != ETH_SFD[3:0]) begin
                  state <= st_drop;
               end
            end

            st_dest_addr: begin
               if (!rx_dv) begin
                  state <= st_idle;
               end else if (byte_done && byte_cnt == LAST_DEST_CNT) begin
                  state <= st_check_addr;
               end
            end

            st_check_addr: begin
               if (dest_shift != STATION_ADDR) begin
                  state <= st_drop;
               end else if (!rx_dv) begin
                  state <= st_idle;
               end else begin
                  state <= st_payload;
               end
            end

            // last byte is written on the edge that sees rx_dv low
            st_payload: begin
               if (!rx_dv) begin
                  state <= st_ready;
               end
            end

            st_ready: begin
               frame_ready <= 1'b1;
               if (frame_ready && frame_ack) begin
                  frame_ready <= 1'b0;
                  state       <= st_release;
               end
            end

            // host still holds ack
            st_release: begin
               if (!frame_ack) begin
                  if (rx_dv) begin
                     state <= st_drop;
                  end else begin
                     state <= st_idle;
                  end
               end
            end

            st_drop: begin
               if (!rx_dv) begin
                  state <= st_idle;
               end
            end

            default: begin
               state <= st_idle;
            end
         endcase
      end
   end

   assign crc_start = (state == st_idle) || (state == st_sfd_low);
   assign wr_addr   = byte_cnt[BUF_ADDR_W-1:0];
   assign wr_data   = nib_shift;
   assign frame_len = byte_cnt;

endmodule

/* design/eth_rx_crc.sv */
`timescale 1ns/10ps

module eth_rx_crc (
   input  logic              RX_CLK,
   input  logic              rst_sync,
   input  logic              crc_start,
   input  logic              crc_en,
   input  eth_rx_pkg::byte_t crc_data,
   output eth_rx_pkg::crc_t  crc_value,
   output logic              crc_ok
);
   import eth_rx_pkg::*;

   crc_t crc_reg;
   crc_t crc_next;

   // one byte through the register, lsb first
   function automatic crc_t crc_byte(input crc_t crc_in, input byte_t data);
      crc_t c;
      c = crc_in;
      for (int i = 0; i < 8; i++) begin
         if (c[0] ^ data[i]) begin
            c = (c >> 1) ^ CRC_POLY;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

   assign crc_next = crc_byte(crc_reg, crc_data);

   // start wins over enable
   always_ff @(posedge RX_CLK or posedge rst_sync) begin
      if (rst_sync) begin
         crc_reg <= '1;
      end else if (crc_start) begin
         crc_reg <= '1;
      end else if (crc_en) begin
         crc_reg <= crc_next;
      end
   end

   // FCS convention, sent inverted
   assign crc_value = ~crc_reg;

   // a good frame leaves the fixed residue
   assign crc_ok = (crc_reg == CRC_RESIDUE);

endmodule

/* design/eth_rx_pkg.sv */
package eth_rx_pkg;

   // MII data is four bits wide
   typedef logic [3:0] nibble_t;

   // one frame byte
   typedef logic [7:0] byte_t;

   // destination and station address
   typedef logic [47:0] mac_addr_t;

   // CRC-32 register and its value
   typedef logic [31:0] crc_t;

   // receiver states
   typedef enum logic [2:0] {
      st_idle,
      st_sfd_low,
      st_dest_addr,
      st_check_addr,
      st_payload,
      st_ready,
      st_release,
      st_drop
   } frame_state_t;

   // start-frame delimiter, as assembled low nibble first
   localparam byte_t ETH_SFD = 8'hD5;

   // destination address length in bytes
   localparam int MAC_ADDR_LEN = 6;

   // reflected CRC-32 polynomial
   localparam crc_t CRC_POLY = 32'hEDB88320;

   // register value after a good frame with its FCS
   localparam crc_t CRC_RESIDUE = 32'hDEBB20E3;

endpackage
